//--- filelist.f
logic/layer_pkg.sv
logic/fp16_cast.sv
logic/line_store.sv
logic/row_fetch.sv
logic/window_former.sv
logic/window_result.sv
logic/input_layer_stream.sv
bench/input_layer_properties.sv
bench/ddr_read_model.sv
bench/window_checker.sv
bench/tb_input_layer.sv

//--- bench/tb_input_layer.sv
`timescale 1ns/1ps
// back-to-back random layer runs checked by window_checker
// run sizes are drawn up front so the cycle limit covers every run
module tb_input_layer;

	localparam int NUM_RUNS = 8;

	logic clk;
	logic reset_n;
	logic start;
	layer_pkg::addr_t base_addr;
	layer_pkg::addr_t row_stride;
	layer_pkg::dim_t rows;
	layer_pkg::dim_t cols;
	logic cast_en;
	layer_pkg::addr_t araddr;
	logic [7:0] arlen;
	logic arvalid;
	logic arready;
	layer_pkg::beat_t rdata;
	logic rvalid;
	logic rlast;
	logic rready;
	layer_pkg::window_t window_data;
	logic window_valid;
	logic window_ready;
	logic done;
	layer_pkg::pixel_t image [layer_pkg::MAX_COLS][layer_pkg::MAX_COLS];
	int test_count;
	int check_count;
	int error_count;
	int prop_errors;
	int cycles;
	int cycle_limit;
	int run_rows [NUM_RUNS];
	int run_cols [NUM_RUNS];
	logic run_cast [NUM_RUNS];
	layer_pkg::addr_t run_base [NUM_RUNS];
	layer_pkg::addr_t run_stride [NUM_RUNS];

	input_layer_stream #(
		.OUT_FIFO_DEPTH (16)
	) dut0 (
		.clk          (clk),
		.reset_n      (reset_n),
		.start        (start),
		.base_addr    (base_addr),
		.row_stride   (row_stride),
		.rows         (rows),
		.cols         (cols),
		.cast_en      (cast_en),
		.araddr       (araddr),
		.arlen        (arlen),
		.arvalid      (arvalid),
		.arready      (arready),
		.rdata        (rdata),
		.rvalid       (rvalid),
		.rlast        (rlast),
		.rready       (rready),
		.window_data  (window_data),
		.window_valid (window_valid),
		.window_ready (window_ready),
		.done         (done)
	);

	ddr_read_model u_ddr (
		.clk        (clk),
		.start      (start),
		.base_addr  (base_addr),
		.row_stride (row_stride),
		.rows       (rows),
		.cols       (cols),
		.araddr     (araddr),
		.arlen      (arlen),
		.arvalid    (arvalid),
		.arready    (arready),
		.rdata      (rdata),
		.rvalid     (rvalid),
		.rlast      (rlast),
		.rready     (rready),
		.image      (image)
	);

	window_checker u_check (
		.clk          (clk),
		.reset_n      (reset_n),
		.start        (start),
		.base_addr    (base_addr),
		.row_stride   (row_stride),
		.rows         (rows),
		.cols         (cols),
		.cast_en      (cast_en),
		.image        (image),
		.araddr       (araddr),
		.arlen        (arlen),
		.arvalid      (arvalid),
		.arready      (arready),
		.window_data  (window_data),
		.window_valid (window_valid),
		.window_ready (window_ready),
		.done         (done),
		.test_count   (test_count),
		.check_count  (check_count),
		.error_count  (error_count)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// consumer takes a window about five cycles in eight
	always @(negedge clk) begin
		window_ready <= ($urandom % 8) < 5;
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycle_limit != 0 && cycles >= cycle_limit) begin
			$display("timeout: runs not finished after %0d cycles", cycles);
			$display("Result: FAILED");
			$finish;
		end
	end

	//----------------------------------------------------------------------
	// run sequence
	//----------------------------------------------------------------------
	initial begin
		int sum;
		void'($urandom(40895));
		reset_n = 1'b0;
		start = 1'b0;
		base_addr = '0;
		row_stride = '0;
		rows = '0;
		cols = '0;
		cast_en = 1'b0;
		window_ready = 1'b0;
		cycles = 0;
		cycle_limit = 0;
		sum = 0;
		for (int i = 0; i < NUM_RUNS; i++) begin
			run_rows[i] = 1 + $urandom % 64;
			run_cols[i] = 1 + $urandom % 64;
			// 1x1, one row, one column and the full size come first
			if (i == 0 || i == 1) begin
				run_rows[i] = 1;
			end
			if (i == 0 || i == 2) begin
				run_cols[i] = 1;
			end
			if (i == 3) begin
				run_rows[i] = 64;
				run_cols[i] = 64;
			end
			run_cast[i] = (i < 4) ? 1'(i % 2) : 1'($urandom % 2);
			run_stride[i] = layer_pkg::addr_t'(((run_cols[i] + 7) / 8) * 16 + 16 * ($urandom % 4));
			run_base[i] = layer_pkg::addr_t'($urandom) & 32'h0fff_fff0;
			sum += run_rows[i] * run_cols[i] * 8;
		end
		cycle_limit = sum + 2000;
		repeat (3) @(negedge clk);
		reset_n = 1'b1;
		for (int i = 0; i < NUM_RUNS; i++) begin
			@(negedge clk);
			rows = layer_pkg::dim_t'(run_rows[i]);
			cols = layer_pkg::dim_t'(run_cols[i]);
			cast_en = run_cast[i];
			base_addr = run_base[i];
			row_stride = run_stride[i];
			start = 1'b1;
			@(negedge clk);
			start = 1'b0;
			while (!done) begin
				@(negedge clk);
			end
			repeat (2 + $urandom % 4) @(negedge clk);
		end
		repeat (4) @(negedge clk);
		prop_errors = dut0.u_fetch.u_ar_props.fail_count + dut0.u_result.u_win_props.fail_count;
		$display("tests %0d of %0d, checks %0d, errors %0d, assertion failures %0d",
			test_count, NUM_RUNS, check_count, error_count, prop_errors);
		if (error_count == 0 && prop_errors == 0 && test_count == NUM_RUNS) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

//--- bench/window_checker.sv
`timescale 1ns/1ps
// reference model for windows, read requests and the done pulse
// one run at a time, the next start only after done
module window_checker (
	input  logic               clk,
	input  logic               reset_n,
	input  logic               start,
	input  layer_pkg::addr_t   base_addr,
	input  layer_pkg::addr_t   row_stride,
	input  layer_pkg::dim_t    rows,
	input  layer_pkg::dim_t    cols,
	input  logic               cast_en,
	input  layer_pkg::pixel_t  image [layer_pkg::MAX_COLS][layer_pkg::MAX_COLS],
	input  layer_pkg::addr_t   araddr,
	input  logic [7:0]         arlen,
	input  logic               arvalid,
	input  logic               arready,
	input  layer_pkg::window_t window_data,
	input  logic               window_valid,
	input  logic               window_ready,
	input  logic               done,
	output int                 test_count,
	output int                 check_count,
	output int                 error_count
);

	logic active;
	logic final_taken;
	logic run_cast;
	int run_rows;
	int run_cols;
	layer_pkg::addr_t run_base;
	layer_pkg::addr_t run_stride;
	int req_count;
	int win_row;
	int win_col;
	int run_errors;

	function automatic layer_pkg::pixel_t model_pixel(input int r, input int c);
		if (r < 0 || r >= run_rows || c < 0 || c >= run_cols) begin
			return 16'd0;
		end
		return image[r][c];
	endfunction

	// half precision with the mantissa cut off below ten bits
	function automatic layer_pkg::pixel_t to_half(input layer_pkg::pixel_t value);
		int mag;
		int lead;
		logic [9:0] frac;
		logic [4:0] expo;
		if (value == 16'd0) begin
			return 16'd0;
		end
		mag = $signed(value);
		if (mag < 0) begin
			mag = -mag;
		end
		lead = 15;
		while (((mag >> lead) & 1) == 0) begin
			lead--;
		end
		if (lead >= 10) begin
			frac = 10'(mag >> (lead - 10));
		end else begin
			frac = 10'(mag << (10 - lead));
		end
		expo = 5'(lead + 15);
		return {value[15], expo, frac};
	endfunction

	function automatic layer_pkg::window_t expected_window(input int r, input int c);
		layer_pkg::window_t w;
		layer_pkg::pixel_t p;
		for (int dr = 0; dr < 3; dr++) begin
			for (int dc = 0; dc < 3; dc++) begin
				p = model_pixel(r + dr - 1, c + dc - 1);
				if (run_cast) begin
					p = to_half(p);
				end
				w[(3*dr + dc)*16 +: 16] = p;
			end
		end
		return w;
	endfunction

	task automatic compare_value(input string name, input logic [143:0] expected,
			input logic [143:0] actual);
		check_count++;
		if (actual !== expected) begin
			$display("ERR %s: expected %0h, actual %0h", name, expected, actual);
			error_count++;
			run_errors++;
		end
	endtask

	task automatic note_failure(input string what);
		$display("test %0d: %s", test_count, what);
		error_count++;
		run_errors++;
	endtask

	task automatic begin_run();
		active = 1'b1;
		run_rows = rows;
		run_cols = cols;
		run_cast = cast_en;
		run_base = base_addr;
		run_stride = row_stride;
		req_count = 0;
		win_row = 0;
		win_col = 0;
		run_errors = 0;
	endtask

	task automatic finish_run();
		compare_value($sformatf("test %0d request count", test_count), run_rows, req_count);
		$display("test %0d: %0dx%0d cast %0d, %0d windows, %0d requests, %0d errors",
			test_count, run_rows, run_cols, run_cast, win_row * run_cols + win_col,
			req_count, run_errors);
		test_count++;
		active = 1'b0;
	endtask

	task automatic check_request();
		layer_pkg::addr_t exp_addr;
		if (!active || req_count >= run_rows) begin
			note_failure("read request beyond the last image row");
		end else begin
			exp_addr = run_base + layer_pkg::addr_t'(req_count) * run_stride;
			compare_value($sformatf("test %0d request %0d araddr", test_count, req_count),
				exp_addr, araddr);
			compare_value($sformatf("test %0d request %0d arlen", test_count, req_count),
				(run_cols + 7) / 8 - 1, arlen);
			req_count++;
		end
	endtask

	task automatic check_window();
		if (!active || win_row >= run_rows) begin
			note_failure("window accepted outside a run or past the last pixel");
		end else begin
			compare_value($sformatf("test %0d window row %0d col %0d", test_count, win_row,
				win_col), expected_window(win_row, win_col), window_data);
			if (win_col == run_cols - 1) begin
				win_col = 0;
				win_row++;
			end else begin
				win_col++;
			end
			if (win_row == run_rows) begin
				final_taken = 1'b1;
			end
		end
	endtask

	//----------------------------------------------------------------------
	// monitor, sampled at the rising edge
	//----------------------------------------------------------------------
	always @(posedge clk) begin
		if (!reset_n) begin
			active = 1'b0;
			final_taken = 1'b0;
			test_count = 0;
			check_count = 0;
			error_count = 0;
		end else begin
			// done belongs to the acceptance one cycle earlier
			if (done) begin
				check_count++;
				if (final_taken) begin
					finish_run();
				end else begin
					note_failure("done pulsed without the last window accepted just before");
				end
			end else if (final_taken) begin
				note_failure("done did not follow the last accepted window");
			end
			final_taken = 1'b0;
			if (start && !active) begin
				begin_run();
			end
			if (arvalid && arready) begin
				check_request();
			end
			if (window_valid && window_ready) begin
				check_window();
			end
		end
	end

endmodule

//--- bench/ddr_read_model.sv
`timescale 1ns/1ps
// AXI read responder, in-order bursts, new random 64x64 image on every start
// bytes outside the image return a pattern made from the byte address
module ddr_read_model (
	input  logic              clk,
	input  logic              start,
	input  layer_pkg::addr_t  base_addr,
	input  layer_pkg::addr_t  row_stride,
	input  layer_pkg::dim_t   rows,
	input  layer_pkg::dim_t   cols,
	input  layer_pkg::addr_t  araddr,
	input  logic [7:0]        arlen,
	input  logic              arvalid,
	output logic              arready,
	output layer_pkg::beat_t  rdata,
	output logic              rvalid,
	output logic              rlast,
	input  logic              rready,
	output layer_pkg::pixel_t image [layer_pkg::MAX_COLS][layer_pkg::MAX_COLS]
);

	layer_pkg::addr_t burst_addr [$];
	int burst_beats [$];
	int beat_no;
	logic beat_taken;

	// zero, -32768, -1 and small values show up often
	function automatic layer_pkg::pixel_t draw_pixel();
		int kind;
		kind = $urandom % 16;
		case (kind)
			0: return 16'h0000;
			1: return 16'h8000;
			2: return 16'hffff;
			3: return 16'($urandom % 64);
			default: return 16'($urandom);
		endcase
	endfunction

	function automatic layer_pkg::beat_t beat_data(input layer_pkg::addr_t addr);
		layer_pkg::beat_t data;
		layer_pkg::addr_t offset;
		layer_pkg::addr_t pix_addr;
		int row;
		int col;
		offset = addr - base_addr;
		row = offset / row_stride;
		for (int j = 0; j < layer_pkg::PIX_PER_BEAT; j++) begin
			pix_addr = addr + layer_pkg::addr_t'(2 * j);
			col = (offset % row_stride) / 2 + j;
			if (row < rows && col < cols) begin
				data[j*16 +: 16] = image[row][col];
			end else begin
				data[j*16 +: 16] = pix_addr[15:0] ^ pix_addr[31:16] ^ 16'h5a3c;
			end
		end
		return data;
	endfunction

	initial begin
		arready = 1'b0;
		rvalid = 1'b0;
		rlast = 1'b0;
		rdata = '0;
		beat_no = 0;
		beat_taken = 1'b0;
	end

	// handshakes seen at the rising edge
	always @(posedge clk) begin
		if (start) begin
			for (int r = 0; r < layer_pkg::MAX_COLS; r++) begin
				for (int c = 0; c < layer_pkg::MAX_COLS; c++) begin
					image[r][c] = draw_pixel();
				end
			end
		end
		if (arvalid && arready) begin
			burst_addr.push_back(araddr);
			burst_beats.push_back(int'(arlen) + 1);
		end
		beat_taken = rvalid && rready;
		if (beat_taken) begin
			beat_no++;
			if (beat_no == burst_beats[0]) begin
				void'(burst_addr.pop_front());
				void'(burst_beats.pop_front());
				beat_no = 0;
			end
		end
	end

	// a beat already offered stays until it is taken
	always @(negedge clk) begin
		arready <= ($urandom % 4) != 0;
		if (!rvalid || beat_taken) begin
			if (burst_addr.size() != 0 && ($urandom % 3) != 0) begin
				rvalid <= 1'b1;
				rdata <= beat_data(burst_addr[0] +
					layer_pkg::addr_t'(beat_no * layer_pkg::BEAT_BYTES));
				rlast <= (beat_no == burst_beats[0] - 1);
			end else begin
				rvalid <= 1'b0;
				rlast <= 1'b0;
			end
		end
	end

endmodule

//--- bench/input_layer_properties.sv
`timescale 1ns/1ps
// valid/ready rules for one channel
// bound onto the AR channel and the window stream
module input_layer_properties #(
	parameter int W = 8
) (
	input  logic         clk,
	input  logic         reset_n,
	input  logic         valid,
	input  logic         ready,
	input  logic [W-1:0] payload
);

	// assertion failures so far
	int fail_count = 0;

	hold_valid: assert property (@(posedge clk) disable iff (!reset_n)
		valid && !ready |=> valid)
		else begin
			$error("valid dropped before the transfer");
			fail_count++;
		end

	hold_payload: assert property (@(posedge clk) disable iff (!reset_n)
		valid && !ready |=> $stable(payload))
		else begin
			$error("payload changed while waiting for ready");
			fail_count++;
		end

	idle_after_reset: assert property (@(posedge clk) !reset_n |=> !valid)
		else begin
			$error("valid high right after reset");
			fail_count++;
		end

endmodule

bind row_fetch input_layer_properties #(.W(40)) u_ar_props (
	.clk     (clk),
	.reset_n (reset_n),
	.valid   (arvalid),
	.ready   (arready),
	.payload ({araddr, arlen})
);

bind window_result input_layer_properties #(.W(144)) u_win_props (
	.clk     (clk),
	.reset_n (reset_n),
	.valid   (window_valid),
	.ready   (window_ready),
	.payload (window_data)
);

//--- logic/input_layer_stream.sv
`timescale 1ns/1ps
// streams one image layer from DDR as 3x3 windows, AXI read channels only
// inputs must stay stable from start until done, OUT_FIFO_DEPTH of 4 or more
module input_layer_stream #(
	parameter int OUT_FIFO_DEPTH = 16
) (
	input  logic               clk,
	input  logic               reset_n,
	input  logic               start,
	input  layer_pkg::addr_t   base_addr,
	input  layer_pkg::addr_t   row_stride,
	input  layer_pkg::dim_t    rows,
	input  layer_pkg::dim_t    cols,
	input  logic               cast_en,
	output layer_pkg::addr_t   araddr,
	output logic [7:0]         arlen,
	output logic               arvalid,
	input  logic               arready,
	input  layer_pkg::beat_t   rdata,
	input  logic               rvalid,
	input  logic               rlast,
	output logic               rready,
	output layer_pkg::window_t window_data,
	output logic               window_valid,
	input  logic               window_ready,
	output logic               done
);

	logic wr_en;
	layer_pkg::slot_t wr_slot;
	layer_pkg::beat_idx_t wr_beat;
	layer_pkg::beat_t wr_data;
	logic row_stored;
	logic row_done;
	layer_pkg::slot_t rd_top;
	layer_pkg::slot_t rd_mid;
	layer_pkg::slot_t rd_bot;
	layer_pkg::dim_t rd_col;
	layer_pkg::window_t rd_window;
	logic push;
	layer_pkg::window_t push_window;
	logic push_last;
	logic space;

	row_fetch u_fetch (
		.clk        (clk),
		.reset_n    (reset_n),
		.start      (start),
		.base_addr  (base_addr),
		.row_stride (row_stride),
		.rows       (rows),
		.cols       (cols),
		.araddr     (araddr),
		.arlen      (arlen),
		.arvalid    (arvalid),
		.arready    (arready),
		.rdata      (rdata),
		.rvalid     (rvalid),
		.rlast      (rlast),
		.rready     (rready),
		.wr_en      (wr_en),
		.wr_slot    (wr_slot),
		.wr_beat    (wr_beat),
		.wr_data    (wr_data),
		.row_stored (row_stored),
		.row_done   (row_done)
	);

	line_store u_store (
		.clk       (clk),
		.wr_en     (wr_en),
		.wr_slot   (wr_slot),
		.wr_beat   (wr_beat),
		.wr_data   (wr_data),
		.rd_top    (rd_top),
		.rd_mid    (rd_mid),
		.rd_bot    (rd_bot),
		.rd_col    (rd_col),
		.rd_window (rd_window)
	);

	window_former u_former (
		.clk         (clk),
		.reset_n     (reset_n),
		.start       (start),
		.rows        (rows),
		.cols        (cols),
		.row_stored  (row_stored),
		.space       (space),
		.rd_window   (rd_window),
		.rd_top      (rd_top),
		.rd_mid      (rd_mid),
		.rd_bot      (rd_bot),
		.rd_col      (rd_col),
		.push        (push),
		.push_window (push_window),
		.push_last   (push_last),
		.row_done    (row_done)
	);

	window_result #(
		.OUT_FIFO_DEPTH (OUT_FIFO_DEPTH)
	) u_result (
		.clk          (clk),
		.reset_n      (reset_n),
		.cast_en      (cast_en),
		.push         (push),
		.push_window  (push_window),
		.push_last    (push_last),
		.space        (space),
		.window_data  (window_data),
		.window_valid (window_valid),
		.window_ready (window_ready),
		.done         (done)
	);

endmodule

//--- logic/window_result.sv
`timescale 1ns/1ps
// optional fp16 cast, one register stage, then an OUT_FIFO_DEPTH window FIFO
// space counts the cast register as taken, so a push is never lost
module window_result #(
	parameter int OUT_FIFO_DEPTH = 16
) (
	input  logic               clk,
	input  logic               reset_n,
	input  logic               cast_en,
	input  logic               push,
	input  layer_pkg::window_t push_window,
	input  logic               push_last,
	output logic               space,
	output layer_pkg::window_t window_data,
	output logic               window_valid,
	input  logic               window_ready,
	output logic               done
);

	localparam int PTR_W = $clog2(OUT_FIFO_DEPTH);
	localparam int CNT_W = $clog2(OUT_FIFO_DEPTH + 1);

	layer_pkg::window_t casted;
	layer_pkg::window_t stage_window;
	logic stage_last;
	logic stage_valid;
	layer_pkg::window_t fifo_window [OUT_FIFO_DEPTH];
	logic fifo_last [OUT_FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic pop;

	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		next_ptr = (ptr == PTR_W'(OUT_FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	for (genvar i = 0; i < 9; i++) begin : g_cast
		fp16_cast u_cast (
			.value  (push_window[i*16 +: 16]),
			.result (casted[i*16 +: 16])
		);
	end

	//----------------------------------------------------------------------
	// cast register
	//----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (push) begin
			stage_window <= cast_en ? casted : push_window;
			stage_last <= push_last;
		end
	end

	//----------------------------------------------------------------------
	// output FIFO
	//----------------------------------------------------------------------
	assign pop = window_valid && window_ready;
	assign window_valid = (count != '0);
	assign window_data = fifo_window[rd_ptr];
	assign space = (count + stage_valid) < OUT_FIFO_DEPTH;

	always_ff @(posedge clk) begin
		if (stage_valid) begin
			fifo_window[wr_ptr] <= stage_window;
			fifo_last[wr_ptr] <= stage_last;
		end
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			stage_valid <= 1'b0;
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			done <= 1'b0;
		end else begin
			stage_valid <= push;
			if (stage_valid) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (pop) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			count <= count + CNT_W'(stage_valid) - CNT_W'(pop);
			// cycle after the last window leaves
			done <= pop && fifo_last[rd_ptr];
		end
	end

endmodule

//--- logic/window_former.sv
`timescale 1ns/1ps
// walks output rows and columns, one window per cycle while space is high
// output row r waits until row min(r+1, rows-1) has been stored
module window_former (
	input  logic               clk,
	input  logic               reset_n,
	input  logic               start,
	input  layer_pkg::dim_t    rows,
	input  layer_pkg::dim_t    cols,
	input  logic               row_stored,
	input  logic               space,
	input  layer_pkg::window_t rd_window,
	output layer_pkg::slot_t   rd_top,
	output layer_pkg::slot_t   rd_mid,
	output layer_pkg::slot_t   rd_bot,
	output layer_pkg::dim_t    rd_col,
	output logic               push,
	output layer_pkg::window_t push_window,
	output logic               push_last,
	output logic               row_done
);

	layer_pkg::walk_state_t state;
	layer_pkg::dim_t out_row;
	layer_pkg::dim_t col;
	layer_pkg::dim_t stored_rows;
	layer_pkg::dim_t need_row;
	layer_pkg::slot_t mid_slot;
	logic first_row;
	logic last_row;
	logic last_col;

	assign first_row = (out_row == 7'd0);
	assign last_row = (out_row == rows - 7'd1);
	assign last_col = (col == cols - 7'd1);
	assign need_row = last_row ? out_row : out_row + 7'd1;

	// slot of row r is r mod 3
	assign rd_mid = mid_slot;
	assign rd_top = (mid_slot == 2'd0) ? 2'd2 : mid_slot - 2'd1;
	assign rd_bot = (mid_slot == 2'd2) ? 2'd0 : mid_slot + 2'd1;
	assign rd_col = col;

	assign push = (state == layer_pkg::walk_emit) && (stored_rows > need_row) && space;
	assign push_last = last_row && last_col;
	assign row_done = push && last_col;

	// zero padding, right column also hides stale pixels past cols
	always_comb begin
		push_window = rd_window;
		if (first_row) begin
			push_window[0 +: 48] = '0;
		end
		if (last_row) begin
			push_window[96 +: 48] = '0;
		end
		if (last_col) begin
			for (int i = 2; i < 9; i += 3) begin
				push_window[i*16 +: 16] = '0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state <= layer_pkg::walk_idle;
			out_row <= '0;
			col <= '0;
			stored_rows <= '0;
			mid_slot <= '0;
		end else begin
			if (row_stored) begin
				stored_rows <= stored_rows + 7'd1;
			end
			case (state)
				layer_pkg::walk_idle: begin
					if (start) begin
						out_row <= '0;
						col <= '0;
						stored_rows <= '0;
						mid_slot <= '0;
						state <= layer_pkg::walk_emit;
					end
				end
				layer_pkg::walk_emit: begin
					if (push && last_col) begin
						col <= '0;
						out_row <= out_row + 7'd1;
						mid_slot <= rd_bot;
						if (last_row) begin
							state <= layer_pkg::walk_done;
						end
					end else if (push) begin
						col <= col + 7'd1;
					end
				end
				default: state <= layer_pkg::walk_idle;
			endcase
		end
	end

endmodule

//--- logic/row_fetch.sv
`timescale 1ns/1ps
// one AXI read burst per image row, arlen = ceil(cols/8) - 1
// row_stride must be a multiple of 16 bytes and cover the whole row
module row_fetch (
	input  logic                 clk,
	input  logic                 reset_n,
	input  logic                 start,
	input  layer_pkg::addr_t     base_addr,
	input  layer_pkg::addr_t     row_stride,
	input  layer_pkg::dim_t      rows,
	input  layer_pkg::dim_t      cols,
	output layer_pkg::addr_t     araddr,
	output logic [7:0]           arlen,
	output logic                 arvalid,
	input  logic                 arready,
	input  layer_pkg::beat_t     rdata,
	input  logic                 rvalid,
	input  logic                 rlast,
	output logic                 rready,
	output logic                 wr_en,
	output layer_pkg::slot_t     wr_slot,
	output layer_pkg::beat_idx_t wr_beat,
	output layer_pkg::beat_t     wr_data,
	output logic                 row_stored,
	input  logic                 row_done
);

	layer_pkg::fetch_state_t state;
	layer_pkg::dim_t row_idx;
	layer_pkg::dim_t done_rows;
	layer_pkg::beat_idx_t last_beat;
	logic beat_ok;
	logic may_request;

	// beats per row minus one
	assign last_beat = layer_pkg::beat_idx_t'((cols - 7'd1) >> 3);
	assign arlen = {5'd0, last_beat};

	assign rready = (state == layer_pkg::fetch_data);
	assign beat_ok = rvalid && rready;
	assign wr_en = beat_ok;
	assign wr_data = rdata;

	// row k overwrites row k-3, last read by output row k-2
	assign may_request = (row_idx <= done_rows + 7'd1);

	//----------------------------------------------------------------------
	// burst sequencing
	//----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state <= layer_pkg::fetch_idle;
			arvalid <= 1'b0;
			row_stored <= 1'b0;
			row_idx <= '0;
			done_rows <= '0;
			wr_slot <= '0;
			wr_beat <= '0;
			araddr <= '0;
		end else begin
			row_stored <= beat_ok && rlast;
			if (row_done) begin
				done_rows <= done_rows + 7'd1;
			end
			case (state)
				layer_pkg::fetch_idle: begin
					if (start) begin
						row_idx <= '0;
						done_rows <= '0;
						wr_slot <= '0;
						araddr <= base_addr;
						state <= layer_pkg::fetch_request;
					end
				end
				layer_pkg::fetch_request: begin
					if (arvalid && arready) begin
						arvalid <= 1'b0;
						wr_beat <= '0;
						state <= layer_pkg::fetch_data;
					end else if (!arvalid && may_request) begin
						arvalid <= 1'b1;
					end
				end
				layer_pkg::fetch_data: begin
					if (beat_ok) begin
						wr_beat <= wr_beat + 3'd1;
						if (rlast) begin
							wr_slot <= (wr_slot == 2'd2) ? 2'd0 : wr_slot + 2'd1;
							araddr <= araddr + row_stride;
							row_idx <= row_idx + 7'd1;
							if (row_idx == rows - 7'd1) begin
								state <= layer_pkg::fetch_done;
							end else begin
								state <= layer_pkg::fetch_request;
							end
						end
					end
				end
				// hold until the window stage has finished every row
				layer_pkg::fetch_done: begin
					if (done_rows == rows) begin
						state <= layer_pkg::fetch_idle;
					end
				end
				default: state <= layer_pkg::fetch_idle;
			endcase
		end
	end

endmodule

//--- logic/line_store.sv
`timescale 1ns/1ps
// three line slots of 64 pixels, write one beat per cycle, read 3x3 combinationally
// columns outside 0..63 read as zero, columns past cols are not masked here
module line_store (
	input  logic                 clk,
	input  logic                 wr_en,
	input  layer_pkg::slot_t     wr_slot,
	input  layer_pkg::beat_idx_t wr_beat,
	input  layer_pkg::beat_t     wr_data,
	input  layer_pkg::slot_t     rd_top,
	input  layer_pkg::slot_t     rd_mid,
	input  layer_pkg::slot_t     rd_bot,
	input  layer_pkg::dim_t      rd_col,
	output layer_pkg::window_t   rd_window
);

	layer_pkg::pixel_t mem [3][layer_pkg::MAX_COLS];
	layer_pkg::slot_t sel [3];

	assign sel[0] = rd_top;
	assign sel[1] = rd_mid;
	assign sel[2] = rd_bot;

	// beat b holds columns 8b to 8b+7
	always_ff @(posedge clk) begin
		if (wr_en) begin
			for (int i = 0; i < layer_pkg::PIX_PER_BEAT; i++) begin
				mem[wr_slot][{wr_beat, 3'(i)}] <= wr_data[i*16 +: 16];
			end
		end
	end

	//----------------------------------------------------------------------
	// window read
	//----------------------------------------------------------------------
	always_comb begin
		logic [7:0] col_ext;
		rd_window = '0;
		for (int r = 0; r < 3; r++) begin
			for (int c = 0; c < 3; c++) begin
				// column -1 wraps to 255 and falls out with the rest
				col_ext = {1'b0, rd_col} + 8'(c) - 8'd1;
				if (col_ext < 8'(layer_pkg::MAX_COLS)) begin
					rd_window[(3*r + c)*16 +: 16] = mem[sel[r]][col_ext[5:0]];
				end
			end
		end
	end

endmodule

//--- logic/fp16_cast.sv
`timescale 1ns/1ps
// signed 16-bit integer to half precision, mantissa truncated
module fp16_cast (
	input  layer_pkg::pixel_t value,
	output layer_pkg::pixel_t result
);

	logic [15:0] mag;
	logic [15:0] norm;
	logic [3:0] lead;
	logic [4:0] exponent;

	// -32768 gives 0x8000, still correct as unsigned
	assign mag = value[15] ? 16'(-value) : value;

	// position of the leading one
	always_comb begin
		lead = '0;
		for (int i = 0; i < 16; i++) begin
			if (mag[i]) begin
				lead = 4'(i);
			end
		end
	end

	// leading one moved up to bit 15, the ten bits below it form the mantissa
	assign norm = mag << (4'd15 - lead);
	assign exponent = {1'b0, lead} + 5'd15;

	assign result = (mag == 16'd0) ? 16'd0 : {value[15], exponent, norm[14:5]};

endmodule

//--- logic/layer_pkg.sv
// shared widths and types for the layer streaming blocks
// images are limited to 64x64 pixels of 16 bits, one 128-bit AXI beat holds 8 pixels
package layer_pkg;

	localparam int BEAT_BYTES = 16;
	localparam int PIX_PER_BEAT = 8;
	localparam int MAX_COLS = 64;

	typedef logic [15:0] pixel_t;
	// lowest column in the lowest bits
	typedef logic [BEAT_BYTES*8-1:0] beat_t;
	// element 3*row_offset + col_offset, top-left in the lowest bits
	typedef logic [9*16-1:0] window_t;
	typedef logic [31:0] addr_t;
	typedef logic [6:0] dim_t;
	typedef logic [1:0] slot_t;
	typedef logic [2:0] beat_idx_t;

	typedef enum logic [1:0] {
		fetch_idle,
		fetch_request,
		fetch_data,
		fetch_done
	} fetch_state_t;

	typedef enum logic [1:0] {
		walk_idle,
		walk_emit,
		walk_done
	} walk_state_t;

endpackage
